/* compile.f */
verilog/hwpe_pkg.sv
verilog/hwpe_regfile.sv
verilog/hwpe_engine.sv
verilog/tcdm_memory.sv
verilog/hwpe_top.sv
tb/tb_hwpe.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; success only when the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hwpe -f compile.f -o sim_hwpe \
  && ./obj_dir/sim_hwpe | tee /dev/stderr | grep -qx "ALL TESTS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* tb/hwpe_vectors.txt */
# Hex fields: W addr be data | R addr tag data err | C reg data | S status
# G waits for the job event | J src dst len coeff offset; memory spans word 400..43F
W 420 F 11223344
W 420 3 0000AABB
W 420 8 CC000000
R 420 1 CC22AABB 0
W 421 F DEADBEEF
W 421 6 00123400
R 421 2 DE1234EF 0
R 420 3 CC22AABB 0
R 421 0 DE1234EF 0
W 400 F 00000003
W 401 F 00000010
W 402 F FFFFFFFF
W 403 F 80000000
W 404 F 12345678
W 405 F 0000FFFF
W 406 F 00000000
W 407 F 7FFFFFFF
W 40F F A5A5A5A5
W 418 F 5A5A5A5A
W 440 F 12345678
R 440 1 00000000 1
R 400 2 00000003 0
W 3FF F 55555555
R 3FF 0 00000000 1
C 0 400
C 1 410
C 2 8
C 3 00010003
C 4 00000100
C 5 1
R 420 1 CC22AABB 0
R 421 2 DE1234EF 0
G
S 2
J 400 410 8 00010003 00000100
W 43E F 00000005
W 43F F 00000006
C 0 43E
C 1 428
C 2 4
C 5 1
G
S 6
C 2 0
C 5 1
G
S 2

/* tb/tb_hwpe.sv */
// Self-checking testbench for the processing engine; replays the command file against hwpe_top
`timescale 1ns/100ps

module tb_hwpe;

  import hwpe_pkg::*;

  localparam int unsigned MEM_WORDS    = 64;
  localparam logic [31:0] BASE_ADDR    = 32'h0000_1000;
  localparam logic [7:0]  STALL_THRESH = 8'd26;
  // First word address of the memory
  localparam addr_t       BASE_WORD    = BASE_ADDR[31:2];
  localparam string       VEC_FILE     = "tb/hwpe_vectors.txt";

  logic      clk;
  logic      rst_n;
  logic      cfg_we_i;
  reg_addr_t cfg_addr_i;
  data_t     cfg_wdata_i;
  data_t     cfg_rdata_o;
  logic      mem_req_i;
  addr_t     mem_add_i;
  logic      mem_opc_i;
  be_t       mem_be_i;
  data_t     mem_wdata_i;
  tag_t      mem_src_i;
  logic      mem_gnt_o;
  data_t     mem_rdata_o;
  logic      mem_valid_o;
  logic      mem_err_o;
  tag_t      mem_src_o;
  logic      evt_o;

  // Reference copy of the memory, filled by host writes and job results
  data_t model_mem   [MEM_WORDS];
  bit    model_known [MEM_WORDS];

  int cycle_cnt   = 0;
  // Zero until the vector file has been sized
  int cycle_limit = 0;
  int evt_seen    = 0;
  int evt_used    = 0;

  hwpe_top #(
    .MEM_WORDS(MEM_WORDS), .BASE_ADDR(BASE_ADDR), .STALL_THRESH(STALL_THRESH)
  ) dut0 (
    .clk(clk), .rst_n(rst_n),
    .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
    .cfg_rdata_o(cfg_rdata_o),
    .mem_req_i(mem_req_i), .mem_add_i(mem_add_i), .mem_opc_i(mem_opc_i),
    .mem_be_i(mem_be_i), .mem_wdata_i(mem_wdata_i), .mem_src_i(mem_src_i),
    .mem_gnt_o(mem_gnt_o), .mem_rdata_o(mem_rdata_o), .mem_valid_o(mem_valid_o),
    .mem_err_o(mem_err_o), .mem_src_o(mem_src_o),
    .evt_o(evt_o)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog on total run length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

  // Completion events, counted so none is lost while other commands run
  always @(negedge clk) begin
    if (evt_o) evt_seen <= evt_seen + 1;
  end

  ////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input data_t got, input data_t expected);
    if (got !== expected) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, expected);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Error: %s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic expect_fields(input int n, input int want);
    if (n != want) abort_run("malformed line in the vector file");
  endtask

  // Word index is an unsigned difference, so addresses below the base wrap high
  function automatic bit in_range(input addr_t add);
    return (add - BASE_WORD) < addr_t'(MEM_WORDS);
  endfunction

  function automatic int word_index(input addr_t add);
    return int'(add - BASE_WORD);
  endfunction

  ////////////////////////////////////////////////////////////
  // Host ports
  ////////////////////////////////////////////////////////////

  task automatic program_reg(input reg_addr_t r, input data_t d);
    @(posedge clk);
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= r;
    cfg_wdata_i <= d;
    @(posedge clk);
    cfg_we_i    <= 1'b0;
  endtask

  // Read mux is combinational
  task automatic check_reg(input reg_addr_t r, input data_t expected);
    @(posedge clk);
    cfg_addr_i <= r;
    @(negedge clk);
    check_eq("cfg_rdata_o", cfg_rdata_o, expected);
  endtask

  // Hold the request until granted; the transfer happens on the next rising edge
  task automatic send_request(input addr_t add, input logic opc, input be_t be,
                              input data_t d, input tag_t tag);
    @(posedge clk);
    mem_req_i   <= 1'b1;
    mem_add_i   <= add;
    mem_opc_i   <= opc;
    mem_be_i    <= be;
    mem_wdata_i <= d;
    mem_src_i   <= tag;
    @(negedge clk);
    while (!mem_gnt_o) @(negedge clk);
    @(posedge clk);
    mem_req_i   <= 1'b0;
  endtask

  task automatic wait_valid();
    @(negedge clk);
    while (!mem_valid_o) @(negedge clk);
  endtask

  task automatic write_word(input addr_t add, input be_t be, input data_t d);
    int wi;
    send_request(add, 1'b1, be, d, 2'd0);
    if (in_range(add)) begin
      wi = word_index(add);
      for (int b = 0; b < 4; b++) begin
        if (be[b]) model_mem[wi][8*b +: 8] = d[8*b +: 8];
      end
      if (be == 4'hF) model_known[wi] = 1'b1;
      // A good write gives no response
      @(negedge clk);
      check_eq("mem_valid_o", 32'(mem_valid_o), 32'd0);
    end else begin
      // Dropped write still reports its error
      wait_valid();
      check_eq("mem_err_o", 32'(mem_err_o), 32'd1);
      check_eq("mem_rdata_o", mem_rdata_o, 32'd0);
    end
  endtask

  task automatic read_word(input addr_t add, input tag_t tag, input data_t expected,
                           input logic expected_err);
    send_request(add, 1'b0, 4'h0, 32'd0, tag);
    wait_valid();
    check_eq("mem_rdata_o", mem_rdata_o, expected);
    check_eq("mem_err_o", 32'(mem_err_o), 32'(expected_err));
    check_eq("mem_src_o", 32'(mem_src_o), 32'(tag));
  endtask

  task automatic wait_event();
    while (evt_seen <= evt_used) @(negedge clk);
    evt_used = evt_used + 1;
  endtask

  ////////////////////////////////////////////////////////////
  // Job result check
  ////////////////////////////////////////////////////////////

  task automatic check_job(input addr_t src, input addr_t dst, input len_t len,
                           input data_t coeff, input data_t offset);
    addr_t s;
    addr_t d;
    addr_t nb;
    data_t expected;
    for (int i = 0; i < int'(len); i++) begin
      s = src + addr_t'(i);
      d = dst + addr_t'(i);
      if (!in_range(s) || !model_known[word_index(s)]) begin
        abort_run("job source word was never loaded by the host");
      end
      // Low 32 bits of element times coefficient plus offset
      expected = model_mem[word_index(s)] * coeff + offset;
      read_word(d, tag_t'(i), expected, 1'b0);
      model_mem[word_index(d)]   = expected;
      model_known[word_index(d)] = 1'b1;
    end
    // Words just outside the destination stay untouched
    nb = dst - addr_t'(1);
    if (in_range(nb) && model_known[word_index(nb)]) begin
      read_word(nb, 2'd3, model_mem[word_index(nb)], 1'b0);
    end
    nb = dst + addr_t'(len);
    if (in_range(nb) && model_known[word_index(nb)]) begin
      read_word(nb, 2'd2, model_mem[word_index(nb)], 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Vector file
  ////////////////////////////////////////////////////////////

  // Dry pass counts memory accesses, the second pass drives the DUT
  task automatic run_vectors(input bit execute, output int accesses);
    int            fd;
    int            n;
    logic [7:0]    cmd;
    data_t         a1, a2, a3, a4, a5;
    logic [1023:0] rest;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) abort_run("cannot open the vector file tb/hwpe_vectors.txt");
    accesses = 0;
    n = $fscanf(fd, " %c", cmd);
    while (n == 1) begin
      case (cmd)
        "#": n = $fgets(rest, fd);
        "W": begin
          n = $fscanf(fd, "%h %h %h", a1, a2, a3);
          expect_fields(n, 3);
          accesses += 1;
          if (execute) write_word(a1[29:0], a2[3:0], a3);
        end
        "R": begin
          n = $fscanf(fd, "%h %h %h %h", a1, a2, a3, a4);
          expect_fields(n, 4);
          accesses += 1;
          if (execute) read_word(a1[29:0], a2[1:0], a3, a4[0]);
        end
        "C": begin
          n = $fscanf(fd, "%h %h", a1, a2);
          expect_fields(n, 2);
          if (execute) program_reg(a1[2:0], a2);
        end
        "S": begin
          n = $fscanf(fd, "%h", a1);
          expect_fields(n, 1);
          if (execute) check_reg(REG_STATUS, a1);
        end
        "G": begin
          if (execute) wait_event();
        end
        "J": begin
          n = $fscanf(fd, "%h %h %h %h %h", a1, a2, a3, a4, a5);
          expect_fields(n, 5);
          // Engine reads and writes plus host readback and two neighbours
          accesses += 3 * int'(a3[15:0]) + 2;
          if (execute) check_job(a1[29:0], a2[29:0], a3[15:0], a4, a5);
        end
        default: abort_run("unknown command in the vector file");
      endcase
      n = $fscanf(fd, " %c", cmd);
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int total;
    // All inputs idle, reset asserted
    rst_n       <= 1'b0;
    cfg_we_i    <= 1'b0;
    cfg_addr_i  <= REG_SRC;
    cfg_wdata_i <= '0;
    mem_req_i   <= 1'b0;
    mem_add_i   <= '0;
    mem_opc_i   <= 1'b0;
    mem_be_i    <= '0;
    mem_wdata_i <= '0;
    mem_src_i   <= '0;
    for (int i = 0; i < int'(MEM_WORDS); i++) model_known[i] = 1'b0;
    run_vectors(1'b0, total);
    cycle_limit = 40 * total + 1000;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    run_vectors(1'b1, total);
    repeat (4) @(posedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* verilog/hwpe_engine.sv */
// Scaling engine FSM: streams a vector through memory port 0, computing x*coeff+offset per element
`timescale 1ns/100ps

module hwpe_engine (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  hwpe_pkg::addr_t src_addr_i,
  input  hwpe_pkg::addr_t dst_addr_i,
  input  hwpe_pkg::len_t  len_i,
  input  hwpe_pkg::data_t coeff_i,
  input  hwpe_pkg::data_t offset_i,
  input  logic            mem_gnt_i,
  input  hwpe_pkg::data_t mem_rdata_i,
  input  logic            mem_valid_i,
  input  logic            mem_err_i,
  output logic            busy_o,
  output logic            done_o,
  output logic            job_err_o,
  output logic            mem_req_o,
  output hwpe_pkg::addr_t mem_add_o,
  output logic            mem_opc_o,
  output hwpe_pkg::be_t   mem_be_o,
  output hwpe_pkg::data_t mem_wdata_o
);

  import hwpe_pkg::*;

  engine_state_t state_q;
  // Element index within the job
  len_t          idx_q;
  logic          err_q;
  // A write was granted last cycle, its error may come back now
  logic          wr_pend_q;
  logic          wr_err;
  logic          done_q;
  logic          job_err_q;
  // Scaled element waiting to be written
  data_t         result_q;

  assign wr_err = wr_pend_q && mem_valid_i && mem_err_i;

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      idx_q     <= '0;
      err_q     <= 1'b0;
      wr_pend_q <= 1'b0;
      done_q    <= 1'b0;
      job_err_q <= 1'b0;
    end else begin
      wr_pend_q <= (state_q == WR_REQ) && mem_gnt_i;
      // Completion pulses follow the DONE cycle
      done_q    <= (state_q == DONE);
      job_err_q <= (state_q == DONE) && (err_q || wr_err);
      case (state_q)
        IDLE: begin
          // A start while busy never reaches here
          if (start_i) begin
            idx_q   <= '0;
            err_q   <= 1'b0;
            state_q <= (len_i == '0) ? DONE : RD_REQ;
          end
        end
        RD_REQ: begin
          if (wr_err) begin
            err_q   <= 1'b1;
            state_q <= DONE;
          end else if (mem_gnt_i) begin
            state_q <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (mem_valid_i) begin
            if (mem_err_i) begin
              err_q   <= 1'b1;
              state_q <= DONE;
            end else begin
              state_q <= WR_REQ;
            end
          end
        end
        WR_REQ: begin
          if (mem_gnt_i) begin
            if (idx_q == len_i - 16'd1) begin
              state_q <= DONE;
            end else begin
              idx_q   <= idx_q + 16'd1;
              state_q <= RD_REQ;
            end
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Scale: low 32 bits of data*coeff+offset
  always_ff @(posedge clk) begin
    if (state_q == RD_WAIT && mem_valid_i) begin
      result_q <= mem_rdata_i * coeff_i + offset_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory request
  ////////////////////////////////////////////////////////////

  // No read is raised once a write error is seen
  assign mem_req_o   = ((state_q == RD_REQ) && !wr_err) || (state_q == WR_REQ);
  assign mem_opc_o   = (state_q == WR_REQ);
  assign mem_add_o   = (state_q == WR_REQ) ? dst_addr_i + addr_t'(idx_q)
                                           : src_addr_i + addr_t'(idx_q);
  assign mem_be_o    = 4'hF;
  assign mem_wdata_o = result_q;

  assign busy_o    = (state_q != IDLE);
  assign done_o    = done_q;
  assign job_err_o = job_err_q;

  // Request held unchanged through a withheld grant
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_add_o) && $stable(mem_opc_o)
      && $stable(mem_wdata_o));

  // Responses only follow a grant
  a_valid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    mem_valid_i |-> $past(mem_req_o && mem_gnt_i));

  // A read always answers in RD_WAIT
  a_valid_in_rd_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == RD_WAIT) |-> mem_valid_i);

endmodule

/* verilog/hwpe_pkg.sv */
// Shared types, register map and engine states, imported by every module of the processing engine
package hwpe_pkg;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  // Word address on the memory bus
  typedef logic [29:0] addr_t;
  // Memory and register data word
  typedef logic [31:0] data_t;
  // One enable per byte lane
  typedef logic [3:0]  be_t;
  // Requester tag, echoed back with the response
  typedef logic [1:0]  tag_t;
  // Configuration register index
  typedef logic [2:0]  reg_addr_t;
  // Vector length in elements
  typedef logic [15:0] len_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  localparam reg_addr_t REG_SRC    = 3'd0;
  localparam reg_addr_t REG_DST    = 3'd1;
  localparam reg_addr_t REG_LEN    = 3'd2;
  localparam reg_addr_t REG_COEFF  = 3'd3;
  localparam reg_addr_t REG_OFFSET = 3'd4;
  // Write only, bit 0 starts a job
  localparam reg_addr_t REG_CTRL   = 3'd5;
  // Read only, bit 0 busy, bit 1 done, bit 2 err
  localparam reg_addr_t REG_STATUS = 3'd6;

  ////////////////////////////////////////////////////////////
  // Engine FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    DONE
  } engine_state_t;

endpackage

/* verilog/hwpe_regfile.sv */
// Host-visible job and status registers; decodes control writes into the engine start pulse
`timescale 1ns/100ps

module hwpe_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cfg_we_i,
  input  hwpe_pkg::reg_addr_t cfg_addr_i,
  input  hwpe_pkg::data_t     cfg_wdata_i,
  input  logic                busy_i,
  input  logic                done_i,
  input  logic                job_err_i,
  output hwpe_pkg::data_t     cfg_rdata_o,
  output hwpe_pkg::addr_t     src_addr_o,
  output hwpe_pkg::addr_t     dst_addr_o,
  output hwpe_pkg::len_t      len_o,
  output hwpe_pkg::data_t     coeff_o,
  output hwpe_pkg::data_t     offset_o,
  output logic                start_o
);

  import hwpe_pkg::*;

  addr_t src_q;
  addr_t dst_q;
  len_t  len_q;
  data_t coeff_q;
  data_t offset_q;
  logic  start_q;
  // Sticky status bits
  logic  done_q;
  logic  err_q;

  ////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      src_q    <= '0;
      dst_q    <= '0;
      len_q    <= '0;
      coeff_q  <= '0;
      offset_q <= '0;
      start_q  <= 1'b0;
    end else begin
      // Start pulse lasts exactly one cycle
      start_q <= cfg_we_i && (cfg_addr_i == REG_CTRL) && cfg_wdata_i[0];
      if (cfg_we_i) begin
        case (cfg_addr_i)
          REG_SRC:    src_q    <= cfg_wdata_i[29:0];
          REG_DST:    dst_q    <= cfg_wdata_i[29:0];
          REG_LEN:    len_q    <= cfg_wdata_i[15:0];
          REG_COEFF:  coeff_q  <= cfg_wdata_i;
          REG_OFFSET: offset_q <= cfg_wdata_i;
          default:    ;
        endcase
      end
    end
  end

  // Done and err held until the next start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
    end else if (start_q) begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      if (done_i) done_q <= 1'b1;
      if (job_err_i) err_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (cfg_addr_i)
      REG_SRC:    cfg_rdata_o = {2'b00, src_q};
      REG_DST:    cfg_rdata_o = {2'b00, dst_q};
      REG_LEN:    cfg_rdata_o = {16'h0000, len_q};
      REG_COEFF:  cfg_rdata_o = coeff_q;
      REG_OFFSET: cfg_rdata_o = offset_q;
      REG_STATUS: cfg_rdata_o = {29'd0, err_q, done_q, busy_i};
      // Control reads back as zero
      default:    cfg_rdata_o = '0;
    endcase
  end

  assign src_addr_o = src_q;
  assign dst_addr_o = dst_q;
  assign len_o      = len_q;
  assign coeff_o    = coeff_q;
  assign offset_o   = offset_q;
  assign start_o    = start_q;

  // Engine reports completion only after a busy cycle
  a_done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> $past(busy_i));

endmodule

/* verilog/hwpe_top.sv */
// Top level of the processing engine: register block, scaling engine and shared memory
`timescale 1ns/100ps

module hwpe_top #(
  parameter int unsigned MEM_WORDS    = 64,
  parameter logic [31:0] BASE_ADDR    = 32'h0000_1000,
  parameter logic [7:0]  STALL_THRESH = 8'd26
) (
  input  logic                clk,
  input  logic                rst_n,
  // Host configuration
  input  logic                cfg_we_i,
  input  hwpe_pkg::reg_addr_t cfg_addr_i,
  input  hwpe_pkg::data_t     cfg_wdata_i,
  output hwpe_pkg::data_t     cfg_rdata_o,
  // Host memory port
  input  logic                mem_req_i,
  input  hwpe_pkg::addr_t     mem_add_i,
  input  logic                mem_opc_i,
  input  hwpe_pkg::be_t       mem_be_i,
  input  hwpe_pkg::data_t     mem_wdata_i,
  input  hwpe_pkg::tag_t      mem_src_i,
  output logic                mem_gnt_o,
  output hwpe_pkg::data_t     mem_rdata_o,
  output logic                mem_valid_o,
  output logic                mem_err_o,
  output hwpe_pkg::tag_t      mem_src_o,
  // Job completion event
  output logic                evt_o
);

  import hwpe_pkg::*;

  // Job setup
  addr_t src_addr, dst_addr;
  len_t  len;
  data_t coeff, offset;
  logic  start, busy, done, job_err;

  // Engine to memory port 0
  logic  eng_req, eng_opc, eng_gnt, eng_valid, eng_err;
  addr_t eng_add;
  be_t   eng_be;
  data_t eng_wdata, eng_rdata;

  hwpe_regfile u_regfile (
    .clk(clk), .rst_n(rst_n),
    .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
    .busy_i(busy), .done_i(done), .job_err_i(job_err),
    .cfg_rdata_o(cfg_rdata_o), .src_addr_o(src_addr), .dst_addr_o(dst_addr),
    .len_o(len), .coeff_o(coeff), .offset_o(offset), .start_o(start)
  );

  hwpe_engine u_engine (
    .clk(clk), .rst_n(rst_n), .start_i(start),
    .src_addr_i(src_addr), .dst_addr_i(dst_addr), .len_i(len),
    .coeff_i(coeff), .offset_i(offset),
    .mem_gnt_i(eng_gnt), .mem_rdata_i(eng_rdata), .mem_valid_i(eng_valid),
    .mem_err_i(eng_err), .busy_o(busy), .done_o(done), .job_err_o(job_err),
    .mem_req_o(eng_req), .mem_add_o(eng_add), .mem_opc_o(eng_opc),
    .mem_be_o(eng_be), .mem_wdata_o(eng_wdata)
  );

  // Engine tag fixed at zero, its echo unused
  tcdm_memory #(
    .MEM_WORDS(MEM_WORDS), .BASE_ADDR(BASE_ADDR), .STALL_THRESH(STALL_THRESH)
  ) u_memory (
    .clk(clk), .rst_n(rst_n),
    .p0_req_i(eng_req), .p0_add_i(eng_add), .p0_opc_i(eng_opc), .p0_be_i(eng_be),
    .p0_din_i(eng_wdata), .p0_src_i(2'b00), .p0_gnt_o(eng_gnt), .p0_dout_o(eng_rdata),
    .p0_valid_o(eng_valid), .p0_err_o(eng_err), .p0_src_o(),
    .p1_req_i(mem_req_i), .p1_add_i(mem_add_i), .p1_opc_i(mem_opc_i), .p1_be_i(mem_be_i),
    .p1_din_i(mem_wdata_i), .p1_src_i(mem_src_i), .p1_gnt_o(mem_gnt_o),
    .p1_dout_o(mem_rdata_o), .p1_valid_o(mem_valid_o), .p1_err_o(mem_err_o),
    .p1_src_o(mem_src_o)
  );

  assign evt_o = done;

endmodule

/* verilog/tcdm_memory.sv */
// Two-port word memory with LFSR grant stalls on port 0, host priority, byte enables and range errors
`timescale 1ns/100ps

module tcdm_memory #(
  parameter int unsigned MEM_WORDS    = 64,
  parameter logic [31:0] BASE_ADDR    = 32'h0000_1000,
  parameter logic [7:0]  STALL_THRESH = 8'd26
) (
  input  logic            clk,
  input  logic            rst_n,
  // Port 0, engine side
  input  logic            p0_req_i,
  input  hwpe_pkg::addr_t p0_add_i,
  input  logic            p0_opc_i,
  input  hwpe_pkg::be_t   p0_be_i,
  input  hwpe_pkg::data_t p0_din_i,
  input  hwpe_pkg::tag_t  p0_src_i,
  output logic            p0_gnt_o,
  output hwpe_pkg::data_t p0_dout_o,
  output logic            p0_valid_o,
  output logic            p0_err_o,
  output hwpe_pkg::tag_t  p0_src_o,
  // Port 1, host side
  input  logic            p1_req_i,
  input  hwpe_pkg::addr_t p1_add_i,
  input  logic            p1_opc_i,
  input  hwpe_pkg::be_t   p1_be_i,
  input  hwpe_pkg::data_t p1_din_i,
  input  hwpe_pkg::tag_t  p1_src_i,
  output logic            p1_gnt_o,
  output hwpe_pkg::data_t p1_dout_o,
  output logic            p1_valid_o,
  output logic            p1_err_o,
  output hwpe_pkg::tag_t  p1_src_o
);

  import hwpe_pkg::*;

  localparam int    IDX_W     = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam addr_t BASE_WORD = addr_t'(BASE_ADDR >> 2);

  data_t       mem_q [MEM_WORDS];
  logic [15:0] lfsr_q;
  logic        stall;

  // Per-port views, index 0 engine, index 1 host
  logic [1:0] req, opc, gnt, acc, in_rng;
  addr_t      add [2];
  addr_t      idx [2];
  be_t        be  [2];
  data_t      din [2];
  tag_t       src [2];
  data_t      dout_q [2];
  tag_t       src_q  [2];
  logic [1:0] valid_q, err_q;

  assign req    = {p1_req_i, p0_req_i};
  assign opc    = {p1_opc_i, p0_opc_i};
  assign add[0] = p0_add_i;
  assign add[1] = p1_add_i;
  assign be[0]  = p0_be_i;
  assign be[1]  = p1_be_i;
  assign din[0] = p0_din_i;
  assign din[1] = p1_din_i;
  assign src[0] = p0_src_i;
  assign src[1] = p1_src_i;

  ////////////////////////////////////////////////////////////
  // Stall generator and arbitration
  ////////////////////////////////////////////////////////////

  // Maximal-length 16-bit LFSR, taps 16 14 13 11
  always_ff @(posedge clk) begin
    if (!rst_n) lfsr_q <= 16'hACE1;
    else        lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
  end

  assign stall  = (lfsr_q[7:0] < STALL_THRESH);
  // Host always wins
  assign gnt[1] = req[1];
  assign gnt[0] = req[0] && !req[1] && !stall;
  assign acc    = req & gnt;

  // Below the base the difference wraps high and fails the check
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      idx[p]    = add[p] - BASE_WORD;
      in_rng[p] = (idx[p] < addr_t'(MEM_WORDS));
    end
  end

  ////////////////////////////////////////////////////////////
  // Array access and responses
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (acc[p] && opc[p] && in_rng[p]) begin
        for (int b = 0; b < 4; b++) begin
          if (be[p][b]) mem_q[idx[p][IDX_W-1:0]][8*b +: 8] <= din[p][8*b +: 8];
        end
      end
      // Out-of-range accesses answer with zero
      if (acc[p] && (!opc[p] || !in_rng[p])) begin
        dout_q[p] <= in_rng[p] ? mem_q[idx[p][IDX_W-1:0]] : '0;
      end
      if (acc[p]) src_q[p] <= src[p];
    end
  end

  // Reads and dropped writes give valid one cycle later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
      err_q   <= '0;
    end else begin
      valid_q <= acc & (~opc | ~in_rng);
      err_q   <= acc & ~in_rng;
    end
  end

  assign p0_gnt_o   = gnt[0];
  assign p0_dout_o  = dout_q[0];
  assign p0_valid_o = valid_q[0];
  assign p0_err_o   = err_q[0];
  assign p0_src_o   = src_q[0];
  assign p1_gnt_o   = gnt[1];
  assign p1_dout_o  = dout_q[1];
  assign p1_valid_o = valid_q[1];
  assign p1_err_o   = err_q[1];
  assign p1_src_o   = src_q[1];

  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(gnt[0] && gnt[1]));

endmodule
